// ==== sources.f ====
+incdir+.
rp_pkg.sv
adc_frontend.sv
apb_region_decoder.sv
hk_regs.sv
trig_regs.sv
trig_detect.sv
rp_top.sv
tb_rp_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_rp_top
RTL_TOP   := rp_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rp_top.sv ====
`timescale 1ns/1ps
`include "rp_consts.svh"

module tb_rp_top;

  import rp_pkg::*;

  localparam int PERIOD   = 100;                          // ns
  localparam int N_ACC    = 64;                           // apb accesses, 3 clocks each
  localparam int N_STEP   = 48;                           // sample steps and waits
  localparam int LIMIT_NS = (N_ACC * 3 + N_STEP) * PERIOD * 4;
  localparam apb_addr_t HK_BASE   = 32'h0000_0000;        // region 0
  localparam apb_addr_t TRIG_BASE = 32'h0010_0000;        // region 1

  logic adc_clk, reset_i;
  adc_raw_t adc_dat_a_i, adc_dat_b_i;
  logic psel_i, penable_i, pwrite_i;
  apb_addr_t paddr_i;
  apb_data_t pwdata_i, prdata_o;
  logic pready_o, pslverr_o, trig_o, armed_o;
  led_t led_o;
  exp_t exp_p_i, exp_n_i, exp_p_o, exp_n_o, exp_p_oe_o, exp_n_oe_o;

  integer seed;                                 // $random state
  led_t sh_led;                                 // shadows of written registers
  exp_t sh_pdir, sh_ndir, sh_pout, sh_nout;
  logic sh_ext, m_armed;                        // trigger model
  adc_smp_t sh_thr, m_cap_a, m_cap_b, lo, hi;
  apb_data_t m_cnt, rd;
  adc_raw_t raw_a;
  logic trig_allowed;                           // a pulse is legal now
  int trig_seen;                                // pulses seen by the monitor

  rp_top dut_i (.*);

  always #(PERIOD / 2) adc_clk = ~adc_clk;

  // ------------------------------------------------------------
  // reference model

  // negative slope, so the full raw code is the most negative sample
  function automatic adc_smp_t to_smp(input adc_raw_t raw);
    to_smp = adc_smp_t'(raw ^ 14'h1fff);
  endfunction

  // the mapping is its own inverse
  function automatic adc_raw_t raw_for(input adc_smp_t smp);
    raw_for = adc_raw_t'(to_smp(adc_raw_t'(smp)));
  endfunction

  function automatic logic crosses(input adc_smp_t prev, input adc_smp_t cur,
                                   input adc_smp_t thr);
    crosses = (prev < thr) && (cur >= thr);     // rising, at or above counts
  endfunction

  function automatic apb_data_t sign_ext(input adc_smp_t smp);
    sign_ext = apb_data_t'(int'(smp));          // signed widening
  endfunction

  function automatic apb_data_t exp_read(input apb_addr_t a);
    logic [`RP_REGION_LSB-1:0] ofs;
    logic [2:0] region;
    ofs = a[`RP_REGION_LSB-1:0];
    region = a[`RP_REGION_MSB:`RP_REGION_LSB];
    exp_read = '0;                              // holes and unmapped regions
    if (region == `RP_REGION_HK) begin
      case (ofs)
        `RP_HK_ID_OFS:   exp_read = `RP_HK_ID;
        `RP_HK_LED_OFS:  exp_read = {24'h0, sh_led};
        `RP_HK_PDIR_OFS: exp_read = {24'h0, sh_pdir};
        `RP_HK_NDIR_OFS: exp_read = {24'h0, sh_ndir};
        `RP_HK_POUT_OFS: exp_read = {24'h0, sh_pout};
        `RP_HK_NOUT_OFS: exp_read = {24'h0, sh_nout};
        `RP_HK_PIN_OFS:  exp_read = {24'h0, exp_p_i};  // held for 2+ cycles
        `RP_HK_NIN_OFS:  exp_read = {24'h0, exp_n_i};
        default: ;
      endcase
    end else if (region == `RP_REGION_TRIG) begin
      case (ofs)
        `RP_TRIG_CTRL_OFS: exp_read = {30'h0, sh_ext, m_armed};
        `RP_TRIG_THR_OFS:  exp_read = sign_ext(sh_thr);
        `RP_TRIG_CNT_OFS:  exp_read = m_cnt;
        `RP_TRIG_CAPA_OFS: exp_read = sign_ext(m_cap_a);
        `RP_TRIG_CAPB_OFS: exp_read = sign_ext(m_cap_b);
        default: ;
      endcase
    end
  endfunction

  // ------------------------------------------------------------
  // checks

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_smp(input string name, input adc_smp_t got, input adc_smp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
  endtask

  task automatic check_exp(input string name, input exp_t got, input exp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // flags any trigger pulse the stimulus did not set up
  always @(negedge adc_clk) begin
    if (!reset_i && trig_o === 1'b1) begin
      if (!trig_allowed)
        stop_on_error("trig_o pulsed without an armed crossing or edge");
      else
        trig_seen++;
    end
  end

  initial begin
    #(LIMIT_NS);
    stop_on_error("timeout, the run did not finish in the expected time");
  end

  // ------------------------------------------------------------
  // bus and wait helpers

  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            input logic err_exp, output apb_data_t rdata);
    @(negedge adc_clk);
    psel_i    = 1'b1;                           // setup phase
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge adc_clk);
    penable_i = 1'b1;                           // access phase
    #1;
    check_bit("pready_o", pready_o, 1'b1);
    check_bit("pslverr_o", pslverr_o, err_exp);
    rdata = prdata_o;
    @(negedge adc_clk);                         // write landed on the posedge
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    apb_access(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic read_check(input apb_addr_t addr);
    apb_data_t got;
    apb_access(1'b0, addr, '0, 1'b0, got);
    check_data($sformatf("prdata_o@%08h", addr), got, exp_read(addr));
  endtask

  task automatic wait_trig(input int max_cyc);
    int n;
    n = 0;
    while (trig_o !== 1'b1) begin
      if (n == max_cyc)
        stop_on_error("trig_o pulse did not arrive");
      else begin
        @(negedge adc_clk);
        n++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // stimulus

  initial begin
    seed = 32'hede9_6ee0;
    adc_clk = 1'b0;
    reset_i = 1'b1;
    {psel_i, penable_i, pwrite_i} = 3'b000;
    paddr_i = '0;
    pwdata_i = '0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    exp_p_i = exp_t'($random(seed)) & 8'hfe;    // p[0] low until the edge test
    exp_n_i = exp_t'($random(seed));
    {sh_led, sh_pdir, sh_ndir, sh_pout, sh_nout} = '0;
    {sh_ext, m_armed, sh_thr, m_cnt, m_cap_a, m_cap_b} = '0;
    trig_allowed = 1'b0;
    trig_seen = 0;
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    reset_i = 1'b0;

    // reset values and id
    check_exp("led_o", led_o, '0);
    check_exp("exp_p_o", exp_p_o, '0);
    check_exp("exp_n_o", exp_n_o, '0);
    check_exp("exp_p_oe_o", exp_p_oe_o, '0);
    check_exp("exp_n_oe_o", exp_n_oe_o, '0);
    check_bit("trig_o", trig_o, 1'b0);
    check_bit("armed_o", armed_o, 1'b0);
    read_check(HK_BASE + `RP_HK_ID_OFS);

    // housekeeping, two rounds of random data
    repeat (2) begin
      sh_led  = led_t'($random(seed));
      sh_pdir = exp_t'($random(seed));
      sh_ndir = exp_t'($random(seed));
      sh_pout = exp_t'($random(seed));
      sh_nout = exp_t'($random(seed));
      write_reg(HK_BASE + `RP_HK_LED_OFS, {24'h0, sh_led});
      write_reg(HK_BASE + `RP_HK_PDIR_OFS, {24'h0, sh_pdir});
      write_reg(HK_BASE + `RP_HK_NDIR_OFS, {24'h0, sh_ndir});
      write_reg(HK_BASE + `RP_HK_POUT_OFS, {24'h0, sh_pout});
      write_reg(HK_BASE + `RP_HK_NOUT_OFS, {24'h0, sh_nout});
      check_exp("led_o", led_o, sh_led);
      check_exp("exp_p_oe_o", exp_p_oe_o, sh_pdir);
      check_exp("exp_n_oe_o", exp_n_oe_o, sh_ndir);
      check_exp("exp_p_o", exp_p_o, sh_pout);
      check_exp("exp_n_o", exp_n_o, sh_nout);
      for (int o = 0; o < 8; o++) read_check(HK_BASE + apb_addr_t'(o * 4));
    end

    // unmapped regions answer with error and zero, write nothing
    for (int r = 2; r < 8; r++) begin
      apb_access(1'b1, (apb_addr_t'(r) << 20) | `RP_HK_LED_OFS, ~{24'h0, sh_led}, 1'b1, rd);
      apb_access(1'b0, (apb_addr_t'(r) << 20) | `RP_HK_LED_OFS, '0, 1'b1, rd);
      check_data("prdata_o", rd, '0);
    end
    check_exp("led_o", led_o, sh_led);
    read_check(HK_BASE + `RP_HK_LED_OFS);
    read_check(TRIG_BASE + `RP_TRIG_CTRL_OFS);

    // level trigger on channel b
    sh_thr = adc_smp_t'($random(seed) % 4000);
    lo = sh_thr - adc_smp_t'(1 + ($random(seed) & 63));
    hi = sh_thr + adc_smp_t'($random(seed) & 63);
    raw_a = adc_raw_t'($random(seed));
    adc_dat_a_i = raw_a;
    adc_dat_b_i = raw_for(lo);
    write_reg(TRIG_BASE + `RP_TRIG_THR_OFS, sign_ext(sh_thr));
    read_check(TRIG_BASE + `RP_TRIG_THR_OFS);
    write_reg(TRIG_BASE + `RP_TRIG_CTRL_OFS, 32'h1);
    m_armed = 1'b1;
    check_bit("armed_o", armed_o, 1'b1);
    read_check(TRIG_BASE + `RP_TRIG_CTRL_OFS);
    @(negedge adc_clk);
    trig_allowed = crosses(to_smp(raw_for(lo)), to_smp(raw_for(hi)), sh_thr);
    adc_dat_b_i = raw_for(hi);
    wait_trig(8);
    check_bit("armed_o", armed_o, 1'b0);
    m_armed = 1'b0;
    m_cnt++;
    m_cap_a = to_smp(raw_a);
    m_cap_b = to_smp(adc_dat_b_i);
    @(negedge adc_clk);
    trig_allowed = 1'b0;
    for (int o = 0; o < 5; o++) read_check(TRIG_BASE + apb_addr_t'(o * 4));
    apb_access(1'b0, TRIG_BASE + `RP_TRIG_CAPB_OFS, '0, 1'b0, rd);
    check_smp("cap_b", adc_smp_t'(rd[`RP_ADC_BITS-1:0]), hi);

    // external trigger on p[0]
    write_reg(TRIG_BASE + `RP_TRIG_CTRL_OFS, 32'h3);
    sh_ext = 1'b1;
    m_armed = 1'b1;
    @(negedge adc_clk);
    trig_allowed = 1'b1;
    exp_p_i[0] = 1'b1;
    wait_trig(8);
    check_bit("armed_o", armed_o, 1'b0);
    m_armed = 1'b0;
    m_cnt++;
    @(negedge adc_clk);
    trig_allowed = 1'b0;
    for (int o = 0; o < 5; o++) read_check(TRIG_BASE + apb_addr_t'(o * 4));

    // unarmed, neither a crossing nor an edge may fire
    adc_dat_b_i = raw_for(lo);
    write_reg(TRIG_BASE + `RP_TRIG_CTRL_OFS, 32'h0);
    sh_ext = 1'b0;
    adc_dat_a_i = adc_raw_t'($random(seed));      // a wrong capture would show
    adc_dat_b_i = raw_for(hi);
    repeat (6) @(negedge adc_clk);
    write_reg(TRIG_BASE + `RP_TRIG_CTRL_OFS, 32'h2);
    sh_ext = 1'b1;
    exp_p_i[0] = 1'b0;
    repeat (4) @(negedge adc_clk);
    exp_p_i[0] = 1'b1;
    repeat (6) @(negedge adc_clk);
    for (int o = 0; o < 5; o++) read_check(TRIG_BASE + apb_addr_t'(o * 4));
    check_data("trig pulses", apb_data_t'(trig_seen), 32'd2);

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== rp_top.sv ====
`timescale 1ns/1ps

module rp_top (
  input  logic              adc_clk,
  input  logic              reset_i,       // sync, active high
  // fast adc
  input  rp_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_pkg::adc_raw_t  adc_dat_b_i,
  // apb slave port
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  rp_pkg::apb_addr_t paddr_i,
  input  rp_pkg::apb_data_t pwdata_i,
  output rp_pkg::apb_data_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // board io
  output rp_pkg::led_t      led_o,
  input  rp_pkg::exp_t      exp_p_i,
  input  rp_pkg::exp_t      exp_n_i,
  output rp_pkg::exp_t      exp_p_o,
  output rp_pkg::exp_t      exp_n_o,
  output rp_pkg::exp_t      exp_p_oe_o,
  output rp_pkg::exp_t      exp_n_oe_o,
  // trigger status
  output logic              trig_o,
  output logic              armed_o
);

  import rp_pkg::*;

  adc_smp_t  adc_a, adc_b;            // converted samples
  logic      hk_sel, trig_sel;        // region selects
  apb_data_t hk_rdata, trig_rdata;
  exp_t      exp_p_sync;              // synced p side pins
  logic      arm_pulse, ext_sel;
  adc_smp_t  threshold;
  apb_data_t trig_count;
  adc_smp_t  cap_a, cap_b;

  // ------------------------------------------------------------
  // adc and bus decode

  adc_frontend i_frontend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  apb_region_decoder i_decoder (
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .hk_sel_o     (hk_sel),
    .trig_sel_o   (trig_sel),
    .hk_rdata_i   (hk_rdata),
    .trig_rdata_i (trig_rdata)
  );

  // ------------------------------------------------------------
  // register blocks

  hk_regs i_hk (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .psel_i       (hk_sel),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (hk_rdata),
    .led_o        (led_o),
    .exp_p_i      (exp_p_i),
    .exp_n_i      (exp_n_i),
    .exp_p_o      (exp_p_o),
    .exp_n_o      (exp_n_o),
    .exp_p_oe_o   (exp_p_oe_o),
    .exp_n_oe_o   (exp_n_oe_o),
    .exp_p_sync_o (exp_p_sync)
  );

  trig_regs i_trig_regs (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .psel_i       (trig_sel),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (trig_rdata),
    .arm_pulse_o  (arm_pulse),
    .ext_sel_o    (ext_sel),
    .threshold_o  (threshold),
    .armed_i      (armed_o),
    .trig_count_i (trig_count),
    .cap_a_i      (cap_a),
    .cap_b_i      (cap_b)
  );

  // ------------------------------------------------------------
  // trigger

  trig_detect i_trig_detect (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .adc_a_i      (adc_a),
    .adc_b_i      (adc_b),
    .exp_p_sync_i (exp_p_sync),
    .arm_i        (arm_pulse),
    .ext_sel_i    (ext_sel),
    .threshold_i  (threshold),
    .armed_o      (armed_o),
    .trig_o       (trig_o),
    .trig_count_o (trig_count),
    .cap_a_o      (cap_a),
    .cap_b_o      (cap_b)
  );

endmodule

// ==== trig_detect.sv ====
`timescale 1ns/1ps

module trig_detect (
  input  logic              adc_clk,
  input  logic              reset_i,       // sync, active high
  input  rp_pkg::adc_smp_t  adc_a_i,       // converted ch a
  input  rp_pkg::adc_smp_t  adc_b_i,       // converted ch b
  input  rp_pkg::exp_t      exp_p_sync_i,  // bit 0 is the ext trigger
  input  logic              arm_i,
  input  logic              ext_sel_i,
  input  rp_pkg::adc_smp_t  threshold_i,
  output logic              armed_o,
  output logic              trig_o,        // one cycle pulse
  output rp_pkg::apb_data_t trig_count_o,
  output rp_pkg::adc_smp_t  cap_a_o,
  output rp_pkg::adc_smp_t  cap_b_o
);

  import rp_pkg::*;

  adc_smp_t  prev_b_q;     // last ch b sample
  logic      prev_ext_q;   // last ext level
  logic      lvl_fire;     // rising crossing of threshold
  logic      ext_fire;     // rising edge on p[0]
  logic      fire;         // selected source
  logic      armed_q;
  logic      trig_q;
  apb_data_t cnt_q;
  adc_smp_t  cap_a_q, cap_b_q;

  assign lvl_fire = (prev_b_q < threshold_i) && (adc_b_i >= threshold_i);  // signed
  assign ext_fire = exp_p_sync_i[0] & ~prev_ext_q;
  assign fire     = ext_sel_i ? ext_fire : lvl_fire;

  // history, runs regardless of arming
  always_ff @(posedge adc_clk) begin
    prev_b_q <= adc_b_i;
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      prev_ext_q <= 1'b0;
      armed_q    <= 1'b0;
      trig_q     <= 1'b0;
      cnt_q      <= '0;
      cap_a_q    <= '0;
      cap_b_q    <= '0;
    end else begin
      prev_ext_q <= exp_p_sync_i[0];
      trig_q     <= armed_q & fire;
      if (armed_q && fire) begin
        armed_q <= 1'b0;              // fire wins over a new arm
        cap_a_q <= adc_a_i;           // both channels, same sample
        cap_b_q <= adc_b_i;
        cnt_q   <= cnt_q + 1'b1;
      end else if (arm_i) begin
        armed_q <= 1'b1;              // re-arm while armed is a no-op
      end
    end
  end

  assign armed_o      = armed_q;
  assign trig_o       = trig_q;
  assign trig_count_o = cnt_q;
  assign cap_a_o      = cap_a_q;
  assign cap_b_o      = cap_b_q;

  trig_needs_armed: assert property (@(posedge adc_clk) disable iff (reset_i)
    trig_o |-> $past(armed_o))
    else $error("trigger without prior arm");

  trig_one_cycle: assert property (@(posedge adc_clk) disable iff (reset_i)
    trig_o |=> !trig_o)
    else $error("trigger pulse longer than one cycle");

endmodule

// ==== trig_regs.sv ====
`timescale 1ns/1ps
`include "rp_consts.svh"

module trig_regs (
  input  logic              adc_clk,
  input  logic              reset_i,       // sync, active high
  // apb slave, region select
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  rp_pkg::apb_addr_t paddr_i,
  input  rp_pkg::apb_data_t pwdata_i,
  output rp_pkg::apb_data_t prdata_o,
  // to the detector
  output logic              arm_pulse_o,   // one cycle, in the access phase
  output logic              ext_sel_o,     // 1 selects exp p[0]
  output rp_pkg::adc_smp_t  threshold_o,
  // detector status
  input  logic              armed_i,
  input  rp_pkg::apb_data_t trig_count_i,
  input  rp_pkg::adc_smp_t  cap_a_i,
  input  rp_pkg::adc_smp_t  cap_b_i
);

  import rp_pkg::*;

  // sample to bus word, sign kept
  function automatic apb_data_t sext(input adc_smp_t smp);
    sext = {{(`RP_APB_DW-`RP_ADC_BITS){smp[`RP_ADC_BITS-1]}}, smp};
  endfunction

  logic [`RP_REGION_LSB-1:0] ofs;  // offset inside the region
  logic     wr_en;
  logic     ext_sel_q;
  adc_smp_t thr_q;

  assign ofs   = paddr_i[`RP_REGION_LSB-1:0];
  assign wr_en = psel_i & penable_i & pwrite_i;

  // armed rises on the edge that ends this access
  assign arm_pulse_o = wr_en && (ofs == `RP_TRIG_CTRL_OFS) && pwdata_i[0];

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ext_sel_q <= 1'b0;  // level trigger on ch b
      thr_q     <= '0;
    end else if (wr_en) begin
      if (ofs == `RP_TRIG_CTRL_OFS) begin
        ext_sel_q <= pwdata_i[1];
      end
      if (ofs == `RP_TRIG_THR_OFS) begin
        thr_q <= adc_smp_t'(pwdata_i[`RP_ADC_BITS-1:0]);
      end
    end
  end

  // ------------------------------------------------------------
  // read mux

  always_comb begin
    prdata_o = '0;
    case (ofs)
      `RP_TRIG_CTRL_OFS: prdata_o = apb_data_t'({ext_sel_q, armed_i});
      `RP_TRIG_THR_OFS:  prdata_o = sext(thr_q);
      `RP_TRIG_CNT_OFS:  prdata_o = trig_count_i;
      `RP_TRIG_CAPA_OFS: prdata_o = sext(cap_a_i);
      `RP_TRIG_CAPB_OFS: prdata_o = sext(cap_b_i);
      default: ;                       // holes read zero
    endcase
  end

  assign ext_sel_o   = ext_sel_q;
  assign threshold_o = thr_q;

  // apb needs a setup phase between accesses
  arm_single_cycle: assert property (@(posedge adc_clk) disable iff (reset_i)
    arm_pulse_o |=> !arm_pulse_o)
    else $error("arm pulse held for two cycles");

endmodule

// ==== hk_regs.sv ====
`timescale 1ns/1ps
`include "rp_consts.svh"

module hk_regs (
  input  logic              adc_clk,
  input  logic              reset_i,       // sync, active high
  // apb slave, region select
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  rp_pkg::apb_addr_t paddr_i,
  input  rp_pkg::apb_data_t pwdata_i,
  output rp_pkg::apb_data_t prdata_o,
  // board io
  output rp_pkg::led_t      led_o,
  input  rp_pkg::exp_t      exp_p_i,       // async pins
  input  rp_pkg::exp_t      exp_n_i,
  output rp_pkg::exp_t      exp_p_o,
  output rp_pkg::exp_t      exp_n_o,
  output rp_pkg::exp_t      exp_p_oe_o,    // 1 drives the pin
  output rp_pkg::exp_t      exp_n_oe_o,
  output rp_pkg::exp_t      exp_p_sync_o   // for the external trigger
);

  import rp_pkg::*;

  logic [`RP_REGION_LSB-1:0] ofs;  // offset inside the region
  logic wr_en;                     // write at end of access
  led_t led_q;
  exp_t pdir_q, ndir_q;            // output enables
  exp_t pout_q, nout_q;            // output data
  exp_t p_meta_q, p_sync_q;        // p side two-flop sync
  exp_t n_meta_q, n_sync_q;        // n side two-flop sync

  assign ofs   = paddr_i[`RP_REGION_LSB-1:0];
  assign wr_en = psel_i & penable_i & pwrite_i;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      led_q  <= '0;
      pdir_q <= '0;  // all pins inputs after reset
      ndir_q <= '0;
      pout_q <= '0;
      nout_q <= '0;
    end else if (wr_en) begin
      case (ofs)
        `RP_HK_LED_OFS:  led_q  <= pwdata_i[7:0];
        `RP_HK_PDIR_OFS: pdir_q <= pwdata_i[`RP_EXP_BITS-1:0];
        `RP_HK_NDIR_OFS: ndir_q <= pwdata_i[`RP_EXP_BITS-1:0];
        `RP_HK_POUT_OFS: pout_q <= pwdata_i[`RP_EXP_BITS-1:0];
        `RP_HK_NOUT_OFS: nout_q <= pwdata_i[`RP_EXP_BITS-1:0];
        default: ;                         // id, inputs, holes ignore writes
      endcase
    end
  end

  // pins are asynchronous to adc_clk
  always_ff @(posedge adc_clk) begin
    p_meta_q <= exp_p_i;
    p_sync_q <= p_meta_q;
    n_meta_q <= exp_n_i;
    n_sync_q <= n_meta_q;
  end

  // ------------------------------------------------------------
  // read mux

  always_comb begin
    prdata_o = '0;                         // holes read zero
    case (ofs)
      `RP_HK_ID_OFS:   prdata_o = `RP_HK_ID;
      `RP_HK_LED_OFS:  prdata_o = apb_data_t'(led_q);
      `RP_HK_PDIR_OFS: prdata_o = apb_data_t'(pdir_q);
      `RP_HK_NDIR_OFS: prdata_o = apb_data_t'(ndir_q);
      `RP_HK_POUT_OFS: prdata_o = apb_data_t'(pout_q);
      `RP_HK_NOUT_OFS: prdata_o = apb_data_t'(nout_q);
      `RP_HK_PIN_OFS:  prdata_o = apb_data_t'(p_sync_q);
      `RP_HK_NIN_OFS:  prdata_o = apb_data_t'(n_sync_q);
      default: ;
    endcase
  end

  assign led_o        = led_q;
  assign exp_p_o      = pout_q;
  assign exp_n_o      = nout_q;
  assign exp_p_oe_o   = pdir_q;
  assign exp_n_oe_o   = ndir_q;
  assign exp_p_sync_o = p_sync_q;

endmodule

// ==== apb_region_decoder.sv ====
`timescale 1ns/1ps
`include "rp_consts.svh"

module apb_region_decoder (
  // apb from the master
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  rp_pkg::apb_addr_t paddr_i,
  output rp_pkg::apb_data_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // per region selects
  output logic              hk_sel_o,      // region 0
  output logic              trig_sel_o,    // region 1
  // slave read data
  input  rp_pkg::apb_data_t hk_rdata_i,
  input  rp_pkg::apb_data_t trig_rdata_i
);

  import rp_pkg::*;

  logic [`RP_REGION_MSB-`RP_REGION_LSB:0] region;  // addr bits 22..20
  logic      access;      // access phase
  logic      hit_hk;      // region decodes to hk
  logic      hit_trig;    // region decodes to trigger
  logic      unmapped;    // regions 2..7
  apb_data_t rdata_mux;   // data of the hit region

  assign region = paddr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign access = psel_i & penable_i;

  // ------------------------------------------------------------
  // region decode

  always_comb begin
    hit_hk   = 1'b0;
    hit_trig = 1'b0;
    unmapped = 1'b0;
    case (region)
      `RP_REGION_HK:   hit_hk   = 1'b1;
      `RP_REGION_TRIG: hit_trig = 1'b1;
      default:         unmapped = 1'b1;  // nothing lives here
    endcase
  end

  assign hk_sel_o   = psel_i & hit_hk;    // slaves see setup and access
  assign trig_sel_o = psel_i & hit_trig;

  // ------------------------------------------------------------
  // return path

  always_comb begin
    rdata_mux = '0;
    if (hit_hk) begin
      rdata_mux = hk_rdata_i;
    end else if (hit_trig) begin
      rdata_mux = trig_rdata_i;
    end
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata_mux : '0;  // unmapped reads zero
  assign pready_o  = access;                                  // zero wait
  assign pslverr_o = access & unmapped;

  // penable only inside a selected transfer
  penable_needs_psel: assert final (!penable_i || psel_i)
    else $error("apb penable without psel");

endmodule

// ==== adc_frontend.sv ====
`timescale 1ns/1ps
`include "rp_consts.svh"

module adc_frontend (
  input  logic             adc_clk,      // adc data clock
  input  logic             reset_i,      // sync, active high
  input  rp_pkg::adc_raw_t adc_dat_a_i,  // raw ch a
  input  rp_pkg::adc_raw_t adc_dat_b_i,  // raw ch b
  output rp_pkg::adc_smp_t adc_a_o,      // converted ch a
  output rp_pkg::adc_smp_t adc_b_o       // converted ch b
);

  import rp_pkg::*;

  // negative slope unsigned to two's complement
  // msb kept, the rest flipped
  function automatic adc_smp_t to_twos(input adc_raw_t raw);
    to_twos = adc_smp_t'({raw[`RP_ADC_BITS-1], ~raw[`RP_ADC_BITS-2:0]});
  endfunction

  adc_smp_t smp_a_q;  // ch a after conversion
  adc_smp_t smp_b_q;  // ch b after conversion

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      smp_a_q <= '0;
      smp_b_q <= '0;
    end else begin
      smp_a_q <= to_twos(adc_dat_a_i);  // one cycle of latency
      smp_b_q <= to_twos(adc_dat_b_i);
    end
  end

  assign adc_a_o = smp_a_q;
  assign adc_b_o = smp_b_q;

endmodule

// ==== rp_pkg.sv ====
`include "rp_consts.svh"

package rp_pkg;

  // ------------------------------------------------------------
  // adc samples

  typedef logic        [`RP_ADC_BITS-1:0] adc_raw_t;  // unsigned, negative slope
  typedef logic signed [`RP_ADC_BITS-1:0] adc_smp_t;  // two's complement

  // ------------------------------------------------------------
  // bus words

  typedef logic [`RP_APB_AW-1:0] apb_addr_t;  // byte address
  typedef logic [`RP_APB_DW-1:0] apb_data_t;  // full word, no strobes

  // ------------------------------------------------------------
  // board io

  typedef logic [`RP_EXP_BITS-1:0] exp_t;  // one expansion side
  typedef logic [7:0]              led_t;  // led bank

endpackage

// ==== rp_consts.svh ====
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

`define RP_ADC_BITS      14             // fast adc sample width
`define RP_EXP_BITS      8              // expansion connector width
`define RP_APB_AW        32             // apb address width
`define RP_APB_DW        32             // apb data width

`define RP_REGION_MSB    22             // region field top bit
`define RP_REGION_LSB    20             // region field low bit
`define RP_REGION_HK     3'd0           // housekeeping region
`define RP_REGION_TRIG   3'd1           // trigger region

`define RP_HK_ID         32'h5250_0001  // housekeeping id word

`define RP_HK_ID_OFS     20'h00         // id, read only
`define RP_HK_LED_OFS    20'h04         // led register
`define RP_HK_PDIR_OFS   20'h08         // p side direction
`define RP_HK_NDIR_OFS   20'h0C         // n side direction
`define RP_HK_POUT_OFS   20'h10         // p side output
`define RP_HK_NOUT_OFS   20'h14         // n side output
`define RP_HK_PIN_OFS    20'h18         // p side input, synced
`define RP_HK_NIN_OFS    20'h1C         // n side input, synced

`define RP_TRIG_CTRL_OFS 20'h00         // arm and source select
`define RP_TRIG_THR_OFS  20'h04         // channel b threshold
`define RP_TRIG_CNT_OFS  20'h08         // trigger count
`define RP_TRIG_CAPA_OFS 20'h0C         // captured channel a
`define RP_TRIG_CAPB_OFS 20'h10         // captured channel b

`endif
